//--- design/ppu_defines.svh
// PPU defines: register addresses, video memory bases and scanline geometry
`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

// CPU-visible register map
`define PPU_ADDR_LCDC 16'hFF40
`define PPU_ADDR_STAT 16'hFF41
`define PPU_ADDR_SCY  16'hFF42
`define PPU_ADDR_SCX  16'hFF43
`define PPU_ADDR_LY   16'hFF44  // read only
`define PPU_ADDR_LYC  16'hFF45
`define PPU_ADDR_BGP  16'hFF47

`define PPU_TILE_BASE_0 16'h8000  // unsigned tile numbers
`define PPU_TILE_BASE_1 16'h9000  // signed tile numbers
`define PPU_MAP_BASE_0  16'h9800
`define PPU_MAP_BASE_1  16'h9C00

`define PPU_DOTS_PER_LINE (9'd456)
`define PPU_SCAN_DOTS     (9'd80)
`define PPU_VISIBLE_LINES (8'd144)
`define PPU_LAST_LINE     (8'd153)
`define PPU_LINE_PIXELS   (8'd160)

`endif

//--- design/ppu_pkg.sv
// PPU package: mode encoding and the packed types shared between blocks
package ppu_pkg;

    // encoding matches the STAT mode field
    typedef enum logic [1:0] {
        mode_hblank = 2'd0,
        mode_vblank = 2'd1,
        mode_scan   = 2'd2,
        mode_draw   = 2'd3
    } ppu_mode_t;

    typedef struct packed {
        logic       enable;     // bit 7, display on
        logic [1:0] rsvd_hi;    // window bits, not implemented
        logic       tile_sel;   // bit 4, 1 selects 8000 unsigned
        logic       map_sel;    // bit 3, 1 selects 9C00
        logic [1:0] rsvd_lo;    // sprite bits, not implemented
        logic       bg_enable;  // bit 0
    } lcd_ctrl_t;

    typedef struct packed {
        logic [7:0] scy;
        logic [7:0] scx;
    } scroll_t;

    typedef struct packed {
        logic [15:0] addr;
        logic        wr;
        logic        rd;
        logic [7:0]  wdata;
    } mmio_bus_t;

    typedef struct packed {
        logic        rd;
        logic [15:0] addr;
    } vram_req_t;

    typedef struct packed {
        logic [7:0] plane_lo;
        logic [7:0] plane_hi;
    } tile_row_t;

endpackage

//--- design/ppu_regs.sv
// PPU register file: CPU writes, read-back mux, STAT fields and interrupt lines
`timescale 1ns/1ns
`include "ppu_defines.svh"

module ppu_regs (
    input  logic                clk,
    input  logic                rst,
    input  ppu_pkg::mmio_bus_t  mmio,
    output logic [7:0]          rdata,
    input  logic [7:0]          ly,
    input  ppu_pkg::ppu_mode_t  mode,
    output ppu_pkg::lcd_ctrl_t  ctrl,
    output ppu_pkg::scroll_t    scroll,
    output logic [7:0]          lyc,
    output logic                irq_vblank,
    output logic                irq_stat
);

    logic [3:0] stat_en;    // STAT bits 6..3
    logic [7:0] bgp;        // palette, read-back only
    logic       ly_match;

    assign ly_match = (ly == lyc);

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl    <= '0;
            stat_en <= '0;
            scroll  <= '0;
            lyc     <= '0;
            bgp     <= '0;
        end else if (mmio.wr) begin
            case (mmio.addr)
                `PPU_ADDR_LCDC: ctrl       <= ppu_pkg::lcd_ctrl_t'(mmio.wdata);
                `PPU_ADDR_STAT: stat_en    <= mmio.wdata[6:3];  // low bits are status
                `PPU_ADDR_SCY:  scroll.scy <= mmio.wdata;
                `PPU_ADDR_SCX:  scroll.scx <= mmio.wdata;
                `PPU_ADDR_LYC:  lyc        <= mmio.wdata;
                `PPU_ADDR_BGP:  bgp        <= mmio.wdata;
                default: ;                                      // LY and others ignore writes
            endcase
        end
    end

    always_comb begin
        case (mmio.addr)
            `PPU_ADDR_LCDC: rdata = ctrl;
            `PPU_ADDR_STAT: rdata = {1'b1, stat_en, ly_match, mode};
            `PPU_ADDR_SCY:  rdata = scroll.scy;
            `PPU_ADDR_SCX:  rdata = scroll.scx;
            `PPU_ADDR_LY:   rdata = ly;
            `PPU_ADDR_LYC:  rdata = lyc;
            `PPU_ADDR_BGP:  rdata = bgp;
            default:        rdata = 8'hFF;  // open bus
        endcase
    end

    assign irq_vblank = (mode == ppu_pkg::mode_vblank);

    // each STAT source gated by its enable bit
    assign irq_stat = (stat_en[3] & ly_match)
                    | (stat_en[0] & (mode == ppu_pkg::mode_hblank))
                    | (stat_en[1] & (mode == ppu_pkg::mode_vblank))
                    | (stat_en[2] & (mode == ppu_pkg::mode_scan));

endmodule

//--- design/ppu_line_timer.sv
// PPU line timer: dot and line counters with the scan/draw/hblank/vblank sequence
`timescale 1ns/1ns
`include "ppu_defines.svh"

module ppu_line_timer (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    input  logic                draw_done,
    output logic [7:0]          ly,
    output ppu_pkg::ppu_mode_t  mode,
    output logic                line_start
);

    logic [8:0] dot;
    logic [7:0] ly_next;
    logic       line_end;

    assign line_end = (dot == `PPU_DOTS_PER_LINE - 9'd1);
    assign ly_next  = (ly == `PPU_LAST_LINE) ? 8'd0 : ly + 8'd1;

    always_ff @(posedge clk) begin
        if (rst || !enable) begin
            dot        <= '0;   // display off parks at the top of the frame
            ly         <= '0;
            mode       <= ppu_pkg::mode_scan;
            line_start <= 1'b0;
        end else begin
            line_start <= 1'b0;
            if (line_end) begin
                dot  <= '0;
                ly   <= ly_next;
                mode <= (ly_next < `PPU_VISIBLE_LINES) ? ppu_pkg::mode_scan
                                                        : ppu_pkg::mode_vblank;
            end else begin
                dot <= dot + 9'd1;
                case (mode)
                    ppu_pkg::mode_scan: begin
                        if (dot == `PPU_SCAN_DOTS - 9'd1) begin
                            mode       <= ppu_pkg::mode_draw;
                            line_start <= 1'b1;     // high on dot 80
                        end
                    end
                    ppu_pkg::mode_draw: begin
                        if (draw_done) begin
                            mode <= ppu_pkg::mode_hblank;
                        end
                    end
                    default: ;                      // hblank and vblank run to line end
                endcase
            end
        end
    end

endmodule

//--- design/ppu_bg_fetcher.sv
// PPU background fetcher: reads tile map entries and tile row bytes from VRAM
`timescale 1ns/1ns
`include "ppu_defines.svh"

module ppu_bg_fetcher (
    input  logic                clk,
    input  logic                rst,
    input  logic                line_start,
    input  ppu_pkg::lcd_ctrl_t  ctrl,
    input  ppu_pkg::scroll_t    scroll,
    input  logic [7:0]          ly,
    output ppu_pkg::vram_req_t  vram,
    input  logic [7:0]          vram_data,
    input  logic                row_free,
    output logic                row_wr,
    output ppu_pkg::tile_row_t  row
);

    localparam int TILES_PER_LINE = 21;

    typedef enum logic [2:0] {
        st_idle,
        st_map_rd,
        st_map_wait,
        st_lo_rd,
        st_lo_wait,
        st_hi_rd,
        st_hi_wait,
        st_hold
    } fetch_state_t;

    fetch_state_t state;
    logic [4:0]   col;          // tile column in the map, wraps at 32
    logic [4:0]   tiles;        // rows handed over this line
    logic [7:0]   tile_num;
    logic [7:0]   ypos;
    logic [15:0]  map_addr;
    logic [15:0]  tile_base;
    logic [15:0]  tile_off;
    logic [15:0]  tile_addr;
    logic         hi_sel;
    logic         last_tile;
    logic         advance;

    assign ypos      = ly + scroll.scy;
    assign map_addr  = (ctrl.map_sel ? `PPU_MAP_BASE_1 : `PPU_MAP_BASE_0)
                     + {6'd0, ypos[7:3], col};
    assign tile_base = ctrl.tile_sel ? `PPU_TILE_BASE_0 : `PPU_TILE_BASE_1;
    assign tile_off  = {{4{tile_num[7] & ~ctrl.tile_sel}}, tile_num, 4'd0};  // x16, signed at 9000
    assign hi_sel    = (state == st_hi_rd);
    assign tile_addr = tile_base + tile_off + {12'd0, ypos[2:0], hi_sel};

    assign last_tile = (tiles == 5'(TILES_PER_LINE - 1));
    assign advance   = (state == st_hold) && row_free && !line_start;
    assign row_wr    = advance;

    always_comb begin
        vram.rd   = 1'b0;
        vram.addr = tile_addr;
        case (state)
            st_map_rd: begin
                vram.rd   = 1'b1;
                vram.addr = map_addr;
            end
            st_lo_rd, st_hi_rd: vram.rd = 1'b1;
            st_hold: begin
                vram.rd   = advance && !last_tile;  // next map read overlaps the handover
                vram.addr = map_addr;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            col   <= '0;
            tiles <= '0;
        end else if (line_start) begin
            state <= st_map_rd;
            col   <= scroll.scx[7:3];   // coarse scroll only
            tiles <= '0;
        end else begin
            case (state)
                st_map_rd:   state <= st_map_wait;
                st_map_wait: begin
                    col   <= col + 5'd1;
                    state <= st_lo_rd;
                end
                st_lo_rd:    state <= st_lo_wait;
                st_lo_wait:  state <= st_hi_rd;
                st_hi_rd:    state <= st_hi_wait;
                st_hi_wait:  state <= st_hold;
                st_hold: begin
                    if (advance) begin
                        tiles <= tiles + 5'd1;
                        state <= last_tile ? st_idle : st_map_wait;
                    end
                end
                default: ;
            endcase
        end
    end

    // data returns one cycle after each read
    always_ff @(posedge clk) begin
        case (state)
            st_map_wait: tile_num     <= vram_data;
            st_lo_wait:  row.plane_lo <= vram_data;
            st_hi_wait:  row.plane_hi <= vram_data;
            default: ;
        endcase
    end

endmodule

//--- design/ppu_tile_shifter.sv
// PPU tile shifter: one pending tile row and one active row shifted out per pixel
`timescale 1ns/1ns

module ppu_tile_shifter (
    input  logic                clk,
    input  logic                rst,
    input  logic                line_start,
    input  logic                row_wr,
    input  ppu_pkg::tile_row_t  row,
    output logic                row_free,
    input  logic                pop,
    output logic                pix_ok,
    output logic [1:0]          pix
);

    ppu_pkg::tile_row_t pend;
    ppu_pkg::tile_row_t act;
    logic               pend_valid;
    logic [3:0]         remain;     // pixels left in the active row
    logic               drain;

    assign drain    = (remain == 4'd0) || (pop && remain == 4'd1);
    assign row_free = !pend_valid;
    assign pix_ok   = (remain != 4'd0);
    assign pix      = {act.plane_hi[7], act.plane_lo[7]};

    always_ff @(posedge clk) begin
        if (rst || line_start) begin
            pend_valid <= 1'b0;
            remain     <= '0;
        end else if (drain && pend_valid) begin
            pend_valid <= 1'b0;     // pending moves in on the same edge
            remain     <= 4'd8;
        end else begin
            if (pop) begin
                remain <= remain - 4'd1;
            end
            if (row_wr) begin
                pend_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_wr) begin
            pend <= row;
        end
        if (drain && pend_valid) begin
            act <= pend;
        end else if (pop) begin
            act.plane_lo <= {act.plane_lo[6:0], 1'b0};
            act.plane_hi <= {act.plane_hi[6:0], 1'b0};
        end
    end

endmodule

//--- design/ppu_pixel_out.sv
// PPU pixel output: pops background pixels, counts x and signals the end of draw
`timescale 1ns/1ns
`include "ppu_defines.svh"

module ppu_pixel_out (
    input  logic       clk,
    input  logic       rst,
    input  logic       line_start,
    input  logic       in_draw,
    input  logic       bg_enable,
    input  logic       pix_ok,
    input  logic [1:0] pix,
    output logic       pop,
    output logic [1:0] px,
    output logic       px_valid,
    output logic       draw_done
);

    logic [7:0] x;      // pixels emitted on this line

    // leftovers from a cut-short line must not leak out on line_start
    assign pop = in_draw && pix_ok && !line_start && (x < `PPU_LINE_PIXELS);

    always_ff @(posedge clk) begin
        if (rst) begin
            x         <= '0;
            px_valid  <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            px_valid  <= pop;
            draw_done <= pop && (x == `PPU_LINE_PIXELS - 8'd1);
            if (line_start) begin
                x <= '0;
            end else if (pop) begin
                x <= x + 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        px <= bg_enable ? pix : 2'b00;  // disabled background is colour 0
    end

endmodule

//--- design/ppu_top.sv
// PPU top level: register file, line timer and the background pixel pipeline
`timescale 1ns/1ns

module ppu_top (
    input  logic                clk,
    input  logic                rst,
    input  ppu_pkg::mmio_bus_t  mmio,
    output logic [7:0]          rdata,
    output ppu_pkg::vram_req_t  vram,
    input  logic [7:0]          vram_data,
    output ppu_pkg::ppu_mode_t  mode,
    output logic                irq_vblank,
    output logic                irq_stat,
    output logic [1:0]          px,
    output logic                px_valid
);

    ppu_pkg::lcd_ctrl_t ctrl;
    ppu_pkg::scroll_t   scroll;
    ppu_pkg::tile_row_t row;
    logic [7:0]         ly;
    logic               line_start;
    logic               draw_done;
    logic               row_wr;
    logic               row_free;
    logic               pop;
    logic               pix_ok;
    logic [1:0]         pix;

    ppu_regs regs0 (
        .clk(clk), .rst(rst), .mmio(mmio), .rdata(rdata), .ly(ly), .mode(mode),
        .ctrl(ctrl), .scroll(scroll), .lyc(),
        .irq_vblank(irq_vblank), .irq_stat(irq_stat)
    );

    ppu_line_timer timer0 (
        .clk(clk), .rst(rst), .enable(ctrl.enable), .draw_done(draw_done),
        .ly(ly), .mode(mode), .line_start(line_start)
    );

    ppu_bg_fetcher fetch0 (
        .clk(clk), .rst(rst), .line_start(line_start), .ctrl(ctrl), .scroll(scroll),
        .ly(ly), .vram(vram), .vram_data(vram_data),
        .row_free(row_free), .row_wr(row_wr), .row(row)
    );

    ppu_tile_shifter shift0 (
        .clk(clk), .rst(rst), .line_start(line_start), .row_wr(row_wr), .row(row),
        .row_free(row_free), .pop(pop), .pix_ok(pix_ok), .pix(pix)
    );

    ppu_pixel_out pixout0 (
        .clk(clk), .rst(rst), .line_start(line_start),
        .in_draw(mode == ppu_pkg::mode_draw), .bg_enable(ctrl.bg_enable),
        .pix_ok(pix_ok), .pix(pix), .pop(pop), .px(px), .px_valid(px_valid),
        .draw_done(draw_done)
    );

endmodule

//--- tests/ppu_checker.sv
// PPU checker: concurrent assertions on the mode sequence, LY range and VRAM port
`timescale 1ns/1ns

module ppu_checker (
    input  logic               clk,
    input  logic               rst,
    input  ppu_pkg::ppu_mode_t mode,
    input  logic [7:0]         ly,
    input  logic               vram_rd
);

    int fail_count = 0;     // read by the testbench at the end

    // vblank is only left through scan
    no_vblank_to_draw: assert property (@(posedge clk) disable iff (rst)
        (mode == ppu_pkg::mode_vblank) |=> (mode != ppu_pkg::mode_draw))
        else begin
            $error("mode went from vblank straight to draw");
            fail_count++;
        end

    ly_in_range: assert property (@(posedge clk) disable iff (rst) ly <= 8'd153)
        else begin
            $error("ly above last line");
            fail_count++;
        end

    // a read answers after one cycle, so back to back reads mean two in flight
    one_read_in_flight: assert property (@(posedge clk) disable iff (rst)
        vram_rd |=> !vram_rd)
        else begin
            $error("second VRAM read issued while one is in flight");
            fail_count++;
        end

endmodule

bind ppu_top ppu_checker chk0 (
    .clk(clk), .rst(rst), .mode(mode), .ly(ly), .vram_rd(vram.rd)
);

//--- tests/ppu_monitor.sv
// PPU monitor: shadows the registers and VRAM, predicts reads, irqs and pixels, counts errors
`timescale 1ns/1ns
`include "ppu_defines.svh"

module ppu_monitor (
    input  logic               clk,
    input  logic               rst,
    input  ppu_pkg::mmio_bus_t mmio,
    input  logic [7:0]         rdata,
    input  logic [7:0]         ly,
    input  ppu_pkg::ppu_mode_t mode,
    input  logic               irq_vblank,
    input  logic               irq_stat,
    input  logic [1:0]         px,
    input  logic               px_valid
);

    logic [7:0]         vram_img [0:8191];
    ppu_pkg::lcd_ctrl_t sh_ctrl;
    ppu_pkg::ppu_mode_t prev_mode = ppu_pkg::mode_scan;
    logic [7:0]         sh_scy, sh_scx, sh_lyc;
    logic [3:0]         sh_stat;
    logic               pix_check = 1'b0;   // set by the testbench between lines
    int                 x_count = 0;
    int                 checks = 0;
    int                 errors = 0;
    int                 err_mark = 0;

    always @(posedge clk) begin
        if (rst) begin
            sh_ctrl <= '0;
            sh_scy  <= '0;
            sh_scx  <= '0;
            sh_lyc  <= '0;
            sh_stat <= '0;
        end else if (mmio.wr) begin
            case (mmio.addr)
                `PPU_ADDR_LCDC: sh_ctrl <= ppu_pkg::lcd_ctrl_t'(mmio.wdata);
                `PPU_ADDR_STAT: sh_stat <= mmio.wdata[6:3];
                `PPU_ADDR_SCY:  sh_scy  <= mmio.wdata;
                `PPU_ADDR_SCX:  sh_scx  <= mmio.wdata;
                `PPU_ADDR_LYC:  sh_lyc  <= mmio.wdata;
                default: ;
            endcase
        end
    end

    // background colour of screen pixel x on line ly_v from the VRAM image
    function automatic logic [1:0] bg_pixel(input logic [7:0] ly_v, input logic [7:0] x);
        logic [7:0]  ypos;
        logic [4:0]  col;
        logic [15:0] map_a;
        logic [15:0] row_a;
        logic [7:0]  tnum;
        logic [7:0]  lo;
        logic [7:0]  hi;
        int          bitn;
        ypos  = ly_v + sh_scy;
        col   = sh_scx[7:3] + x[7:3];
        map_a = (sh_ctrl.map_sel ? `PPU_MAP_BASE_1 : `PPU_MAP_BASE_0) + ypos[7:3] * 32 + col;
        tnum  = vram_img[map_a[12:0]];
        if (sh_ctrl.tile_sel) row_a = `PPU_TILE_BASE_0 + tnum * 16;
        else row_a = 16'(int'(`PPU_TILE_BASE_1) + int'($signed(tnum)) * 16);
        row_a = row_a + ypos[2:0] * 2;
        lo    = vram_img[row_a[12:0]];
        hi    = vram_img[row_a[12:0] + 13'd1];
        bitn  = 7 - x[2:0];
        return sh_ctrl.bg_enable ? {hi[bitn], lo[bitn]} : 2'b00;
    endfunction

    always @(negedge clk) begin : watch
        logic       exp_irq;
        logic       exp_vb;
        logic [1:0] exp_px;
        if (!rst) begin
            exp_irq = (sh_stat[3] && ly == sh_lyc) || (sh_stat[0] && mode == ppu_pkg::mode_hblank)
                    || (sh_stat[1] && mode == ppu_pkg::mode_vblank)
                    || (sh_stat[2] && mode == ppu_pkg::mode_scan);
            exp_vb  = (ly >= `PPU_VISIBLE_LINES);  // lines 144 to 153
            checks += 3;
            if (irq_stat !== exp_irq) begin
                $display("[ERROR] irq_stat expected %h got %h at ly %h", exp_irq, irq_stat, ly);
                errors++;
            end
            if (irq_vblank !== exp_vb) begin
                $display("[ERROR] irq_vblank expected %h got %h at ly %h", exp_vb,
                         irq_vblank, ly);
                errors++;
            end
            if ((mode == ppu_pkg::mode_vblank) !== exp_vb) begin
                $display("[ERROR] mode got %h at ly %h, vblank expected %h", mode, ly, exp_vb);
                errors++;
            end
            if (prev_mode == ppu_pkg::mode_scan && mode == ppu_pkg::mode_draw) x_count = 0;
            if (px_valid) begin
                if (pix_check) begin
                    exp_px = bg_pixel(ly, 8'(x_count));
                    checks++;
                    if (px !== exp_px) begin
                        $display("[ERROR] px expected %h got %h at ly %h x %h", exp_px, px, ly,
                                 8'(x_count));
                        errors++;
                    end
                end
                x_count++;
            end
            if (pix_check && prev_mode == ppu_pkg::mode_draw && mode == ppu_pkg::mode_hblank) begin
                checks++;
                if (x_count != 160) begin
                    $display("[ERROR] px_valid count expected %h got %h at ly %h", 8'd160,
                             8'(x_count), ly);
                    errors++;
                end
            end
        end
        prev_mode = mode;
    end

    task automatic set_vram(input logic [12:0] a, input logic [7:0] d);
        vram_img[a] = d;
    endtask

    task automatic compare_read(input logic [15:0] a, input logic [7:0] exp);
        #10;    // rdata settles after the address change
        checks++;
        if (rdata !== exp) begin
            $display("[ERROR] rdata at %h expected %h got %h", a, exp, rdata);
            errors++;
        end
    endtask

    task automatic end_test(input int num);
        $display("test %0d finished with %0d errors", num, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic report(input int assert_fails, output int total);
        total = errors + assert_fails;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, assert_fails);
    endtask

endmodule

//--- tests/ppu_tb.sv
// PPU testbench: clock, reset, VRAM model, stim file sequencer and watchdog around the DUT
`timescale 1ns/1ns
`include "ppu_defines.svh"

module ppu_tb;

    localparam longint WATCHDOG_NS = 154 * 456 * 100 * 5 / 2;  // 2.5 frames

    logic               clk;
    logic               rst;
    ppu_pkg::mmio_bus_t mmio;
    logic [7:0]         rdata;
    ppu_pkg::vram_req_t vram;
    logic [7:0]         vram_data;
    ppu_pkg::ppu_mode_t mode;
    logic               irq_vblank;
    logic               irq_stat;
    logic [1:0]         px;
    logic               px_valid;
    logic [7:0]         vram_mem [0:8191];
    logic [31:0]        stim [0:127];
    int                 total_errors;
    int                 bad_ops;

    ppu_top dut0 (
        .clk(clk), .rst(rst), .mmio(mmio), .rdata(rdata), .vram(vram),
        .vram_data(vram_data), .mode(mode), .irq_vblank(irq_vblank),
        .irq_stat(irq_stat), .px(px), .px_valid(px_valid)
    );

    ppu_monitor mon0 (
        .clk(clk), .rst(rst), .mmio(mmio), .rdata(rdata), .ly(dut0.ly), .mode(mode),
        .irq_vblank(irq_vblank), .irq_stat(irq_stat), .px(px), .px_valid(px_valid)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (vram.rd) vram_data <= vram_mem[vram.addr[12:0]];  // one cycle read latency
    end

    task automatic write_reg(input logic [15:0] a, input logic [7:0] d);
        @(negedge clk);
        mmio = '{addr: a, wr: 1'b1, rd: 1'b0, wdata: d};
        @(negedge clk);
        mmio.wr = 1'b0;
    endtask

    task automatic check_reg(input logic [15:0] a, input logic [7:0] exp);
        @(negedge clk);
        mmio = '{addr: a, wr: 1'b0, rd: 1'b1, wdata: 8'h00};
        mon0.compare_read(a, exp);
    endtask

    task automatic wait_ly(input logic [7:0] target);
        @(negedge clk);
        mmio = '{addr: `PPU_ADDR_LY, wr: 1'b0, rd: 1'b1, wdata: 8'h00};
        forever begin
            #1;
            if (rdata == target) break;
            @(negedge clk);
        end
    endtask

    // checks n full draw periods, starting and stopping inside hblank
    task automatic check_lines(input int n);
        int                 seen;
        ppu_pkg::ppu_mode_t last;
        seen = 0;
        @(negedge clk);
        while (mode != ppu_pkg::mode_hblank) @(negedge clk);
        @(negedge clk);
        mon0.pix_check = 1'b1;
        last = mode;
        while (seen < n) begin
            @(negedge clk);
            if (last == ppu_pkg::mode_draw && mode == ppu_pkg::mode_hblank) seen++;
            last = mode;
        end
        @(negedge clk);
        mon0.pix_check = 1'b0;
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        mmio      = '0;
        vram_data = 8'h00;
        bad_ops   = 0;
        void'($urandom(32'h7071_af6e));
        for (int i = 0; i < 8192; i++) begin
            vram_mem[i] = 8'($urandom);
            mon0.set_vram(13'(i), vram_mem[i]);
        end
        for (int i = 0; i < 128; i++) stim[i] = '0;
        $readmemh("tests/ppu_stim.txt", stim);
        if (stim[0][31:24] == 8'h00) begin
            $display("stim file is empty or missing");
            bad_ops++;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 128 && stim[i][31:24] != 8'h00; i++) begin
            case (stim[i][31:24])
                8'h01: begin
                    vram_mem[stim[i][20:8]] = stim[i][7:0];
                    mon0.set_vram(stim[i][20:8], stim[i][7:0]);
                end
                8'h02: write_reg(stim[i][23:8], stim[i][7:0]);
                8'h03: check_reg(stim[i][23:8], stim[i][7:0]);
                8'h04: wait_ly(stim[i][7:0]);
                8'h05: check_lines(int'(stim[i][7:0]));
                8'h07: mon0.end_test(int'(stim[i][7:0]));
                default: begin
                    $display("unknown stim op %h on line %0d", stim[i][31:24], i);
                    bad_ops++;
                end
            endcase
        end
        mon0.report(dut0.chk0.fail_count, total_errors);
        if (total_errors == 0 && bad_ops == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within 2.5 frames");
        $display("Test failed");
        $finish;
    end

endmodule

//--- tests/ppu_stim.txt
// one 32-bit word per line: op[31:24] addr[23:8] data[7:0]
// op 01 vram byte, 02 reg write, 03 reg read check, 04 wait ly, 05 check lines, 07 test end, 00 stop
01_9800_01
01_9801_fe
01_8010_3c
01_8011_7e
02_ff42_12
02_ff43_2b
02_ff45_05
02_ff47_e4
02_ff41_47
02_ff40_11
02_ff44_77
03_ff40_11
03_ff41_c2
03_ff42_12
03_ff43_2b
03_ff44_00
03_ff45_05
03_ff47_e4
03_ff46_ff
07_0000_01
02_ff40_91
03_ff41_c2
04_0000_05
03_ff41_c6
04_0000_06
03_ff41_c2
07_0000_03
04_0000_90
03_ff41_c1
04_0000_99
03_ff41_c1
04_0000_00
03_ff41_c2
07_0000_02
05_0000_03
07_0000_04
02_ff40_89
02_ff42_37
02_ff43_51
05_0000_03
07_0000_05
02_ff40_88
05_0000_02
07_0000_06
00_0000_00

//--- compile.f
+incdir+design
design/ppu_pkg.sv
design/ppu_regs.sv
design/ppu_line_timer.sv
design/ppu_bg_fetcher.sv
design/ppu_tile_shifter.sv
design/ppu_pixel_out.sv
design/ppu_top.sv
tests/ppu_checker.sv
tests/ppu_monitor.sv
tests/ppu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the PPU testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f compile.f \
        --top-module ppu_tb -o ppu_sim; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/ppu_sim +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -qx "Test passed" <<< "$out"; then
    exit 0
fi
exit 1
